// File: cpu_pkg.sv
/*
 * Processor encodings: opcodes, instruction fields, register file size, ALU codes.
 * Opcodes not listed here are treated as HALT by the decoder.
 */
package cpu_pkg;

   localparam int data_width     = 32;
   localparam int reg_count      = 8;
   localparam int reg_addr_width = 3;
   localparam int opcode_width   = 4;
   localparam int alu_op_width   = 3;

   // Instruction field positions
   localparam int opcode_msb = 31;
   localparam int opcode_lsb = 28;
   localparam int rd_msb     = 27;
   localparam int rd_lsb     = 25;
   localparam int rs1_msb    = 24;
   localparam int rs1_lsb    = 22;
   localparam int rs2_msb    = 21;
   localparam int rs2_lsb    = 19;
   localparam int imm_msb    = 15;
   localparam int imm_lsb    = 0;
   localparam int imm_width  = imm_msb - imm_lsb + 1;

   // Opcodes
   localparam logic [opcode_width-1:0] op_add  = 4'h0;
   localparam logic [opcode_width-1:0] op_sub  = 4'h1;
   localparam logic [opcode_width-1:0] op_and  = 4'h2;
   localparam logic [opcode_width-1:0] op_or   = 4'h3;
   localparam logic [opcode_width-1:0] op_xor  = 4'h4;
   localparam logic [opcode_width-1:0] op_addi = 4'h5;
   localparam logic [opcode_width-1:0] op_lui  = 4'h6;
   localparam logic [opcode_width-1:0] op_ld   = 4'h7;
   localparam logic [opcode_width-1:0] op_st   = 4'h8;
   localparam logic [opcode_width-1:0] op_bne  = 4'h9;
   localparam logic [opcode_width-1:0] op_out  = 4'ha;
   localparam logic [opcode_width-1:0] op_halt = 4'hf;

   // ALU operations
   localparam logic [alu_op_width-1:0] alu_add  = 3'd0;
   localparam logic [alu_op_width-1:0] alu_sub  = 3'd1;
   localparam logic [alu_op_width-1:0] alu_and  = 3'd2;
   localparam logic [alu_op_width-1:0] alu_or   = 3'd3;
   localparam logic [alu_op_width-1:0] alu_xor  = 3'd4;
   localparam logic [alu_op_width-1:0] alu_pass = 3'd5;

endpackage

// File: bus_pkg.sv
/*
 * Wishbone bus widths, byte-lane select and the processor start address.
 * Only full-word transfers exist, so SEL is always all lanes.
 */
package bus_pkg;

   localparam int wb_addr_width = 32;
   localparam int wb_data_width = 32;
   localparam int wb_sel_width  = 4;

   localparam logic [wb_sel_width-1:0] wb_sel_all = 4'b1111;

   // Byte address of the first instruction, pc steps by 4
   localparam logic [wb_addr_width-1:0] reset_pc = 32'h0000_0000;

   // Parallel output port on the breakout pins
   localparam int out_port_width = 8;

endpackage

// File: wishbone_manager.sv
`timescale 1ns/1ps
/*
 * One Wishbone classic cycle per read or write strobe.
 * Strobes are accepted only while busy_o is low; the slave sets the latency.
 * Read data is valid on cpu_dat_o once busy_o falls.
 */
module wishbone_manager (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              read_i,
   input  logic                              write_i,
   input  logic [bus_pkg::wb_addr_width-1:0] adr_i,
   input  logic [bus_pkg::wb_sel_width-1:0]  sel_i,
   input  logic [bus_pkg::wb_data_width-1:0] cpu_dat_i,
   output logic [bus_pkg::wb_data_width-1:0] cpu_dat_o,
   output logic                              busy_o,
   input  logic [bus_pkg::wb_data_width-1:0] dat_i,
   input  logic                              ack_i,
   output logic [bus_pkg::wb_addr_width-1:0] adr_o,
   output logic [bus_pkg::wb_data_width-1:0] dat_o,
   output logic [bus_pkg::wb_sel_width-1:0]  sel_o,
   output logic                              we_o,
   output logic                              stb_o,
   output logic                              cyc_o
);

   typedef enum logic {
      s_idle,
      s_active
   } state_t;

   state_t state_q;
   logic   stb_q;
   logic   we_q;
   logic   request;
   logic   done;

   assign request = (state_q == s_idle) && (read_i || write_i);
   // Slave acknowledge ends the cycle
   assign done    = (state_q == s_active) && ack_i;

   // Control state
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= s_idle;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
      end else if (request) begin
         state_q <= s_active;
         stb_q   <= 1'b1;
         we_q    <= write_i;
      end else if (done) begin
         state_q <= s_idle;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
      end
   end

   // Address, data and lanes held for the whole cycle
   always_ff @(posedge clk_i) begin
      if (request) begin
         adr_o <= adr_i;
         dat_o <= cpu_dat_i;
         sel_o <= sel_i;
      end
      // Read data captured in the ACK cycle
      if (done) begin
         cpu_dat_o <= dat_i;
      end
   end

   assign cyc_o  = (state_q == s_active);
   assign stb_o  = stb_q;
   assign we_o   = we_q;
   // High from the cycle after the strobe through the ACK cycle
   assign busy_o = (state_q == s_active);

   a_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
      stb_o |-> cyc_o);

   a_no_request_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      (read_i || write_i) |-> !busy_o);

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps
/*
 * Instruction field split and control levels, purely combinational.
 * Unknown opcodes decode as HALT.
 */
module cpu_decode (
   input  logic [cpu_pkg::data_width-1:0]     instr_i,
   output logic [cpu_pkg::opcode_width-1:0]   opcode_o,
   output logic [cpu_pkg::reg_addr_width-1:0] rd_o,
   output logic [cpu_pkg::reg_addr_width-1:0] rs1_o,
   output logic [cpu_pkg::reg_addr_width-1:0] rs2_o,
   output logic [cpu_pkg::data_width-1:0]     imm_o,
   output logic [cpu_pkg::alu_op_width-1:0]   alu_op_o,
   output logic                               uses_imm_o,
   output logic                               reg_write_o,
   output logic                               mem_read_o,
   output logic                               mem_write_o,
   output logic                               branch_o,
   output logic                               out_write_o,
   output logic                               halt_o
);

   logic [cpu_pkg::imm_width-1:0] imm_raw;

   assign opcode_o = instr_i[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
   assign rd_o     = instr_i[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
   assign rs1_o    = instr_i[cpu_pkg::rs1_msb:cpu_pkg::rs1_lsb];
   assign rs2_o    = instr_i[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb];
   assign imm_raw  = instr_i[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];

   // LUI places the immediate in the upper half, others sign-extend
   assign imm_o = (opcode_o == cpu_pkg::op_lui) ?
                  {imm_raw, {(cpu_pkg::data_width - cpu_pkg::imm_width){1'b0}}} :
                  {{(cpu_pkg::data_width - cpu_pkg::imm_width){imm_raw[cpu_pkg::imm_width-1]}},
                   imm_raw};

   always_comb begin
      alu_op_o    = cpu_pkg::alu_add;
      uses_imm_o  = 1'b0;
      reg_write_o = 1'b0;
      mem_read_o  = 1'b0;
      mem_write_o = 1'b0;
      branch_o    = 1'b0;
      out_write_o = 1'b0;
      halt_o      = 1'b0;
      case (opcode_o)
         cpu_pkg::op_add: begin
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_sub: begin
            alu_op_o    = cpu_pkg::alu_sub;
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_and: begin
            alu_op_o    = cpu_pkg::alu_and;
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_or: begin
            alu_op_o    = cpu_pkg::alu_or;
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_xor: begin
            alu_op_o    = cpu_pkg::alu_xor;
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_addi: begin
            uses_imm_o  = 1'b1;
            reg_write_o = 1'b1;
         end
         cpu_pkg::op_lui: begin
            alu_op_o    = cpu_pkg::alu_pass;
            uses_imm_o  = 1'b1;
            reg_write_o = 1'b1;
         end
         // Address through the adder, rs1 plus immediate
         cpu_pkg::op_ld: begin
            uses_imm_o  = 1'b1;
            reg_write_o = 1'b1;
            mem_read_o  = 1'b1;
         end
         cpu_pkg::op_st: begin
            uses_imm_o  = 1'b1;
            mem_write_o = 1'b1;
         end
         cpu_pkg::op_bne: begin
            branch_o = 1'b1;
         end
         cpu_pkg::op_out: begin
            out_write_o = 1'b1;
         end
         default: begin
            halt_o = 1'b1;
         end
      endcase
   end

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps
/*
 * ALU, effective address and branch decision, combinational.
 * Arithmetic wraps at 32 bits; the branch offset counts words from pc + 4.
 */
module cpu_execute (
   input  logic [cpu_pkg::alu_op_width-1:0] alu_op_i,
   input  logic                             uses_imm_i,
   input  logic [cpu_pkg::data_width-1:0]   rs1_val_i,
   input  logic [cpu_pkg::data_width-1:0]   rs2_val_i,
   input  logic [cpu_pkg::data_width-1:0]   imm_i,
   input  logic [cpu_pkg::data_width-1:0]   pc_i,
   output logic [cpu_pkg::data_width-1:0]   alu_result_o,
   output logic [cpu_pkg::data_width-1:0]   branch_target_o,
   output logic                             operands_differ_o
);

   logic [cpu_pkg::data_width-1:0] operand_b;

   // Second operand is the register or the immediate
   assign operand_b = uses_imm_i ? imm_i : rs2_val_i;

   always_comb begin
      case (alu_op_i)
         cpu_pkg::alu_add:  alu_result_o = rs1_val_i + operand_b;
         cpu_pkg::alu_sub:  alu_result_o = rs1_val_i - operand_b;
         cpu_pkg::alu_and:  alu_result_o = rs1_val_i & operand_b;
         cpu_pkg::alu_or:   alu_result_o = rs1_val_i | operand_b;
         cpu_pkg::alu_xor:  alu_result_o = rs1_val_i ^ operand_b;
         // LUI value straight from the decoder
         cpu_pkg::alu_pass: alu_result_o = imm_i;
         default:           alu_result_o = rs1_val_i + operand_b;
      endcase
   end

   // Word offset from the next instruction
   assign branch_target_o = pc_i + 32'd4 + {imm_i[cpu_pkg::data_width-3:0], 2'b00};

   // BNE condition, always on the two registers
   assign operands_differ_o = (rs1_val_i != rs2_val_i);

endmodule

// File: cpu_result.sv
`timescale 1ns/1ps
/*
 * Register file, program counter, output port and halt flag.
 * Register 0 reads as zero; reads are combinational.
 * The output port takes the low byte of the rs1 read port.
 */
module cpu_result (
   input  logic                                 clk_i,
   input  logic                                 reset_i,
   input  logic                                 reg_write_i,
   input  logic [cpu_pkg::reg_addr_width-1:0]   rd_i,
   input  logic [cpu_pkg::data_width-1:0]       wr_data_i,
   input  logic [cpu_pkg::reg_addr_width-1:0]   rs1_i,
   input  logic [cpu_pkg::reg_addr_width-1:0]   rs2_i,
   output logic [cpu_pkg::data_width-1:0]       rs1_val_o,
   output logic [cpu_pkg::data_width-1:0]       rs2_val_o,
   input  logic                                 pc_step_i,
   input  logic                                 pc_load_i,
   input  logic [cpu_pkg::data_width-1:0]       pc_target_i,
   output logic [cpu_pkg::data_width-1:0]       pc_o,
   input  logic                                 out_write_i,
   output logic [bus_pkg::out_port_width-1:0]   out_data_o,
   input  logic                                 halt_set_i,
   output logic                                 halted_o
);

   logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];

   // Register array, writes to r0 dropped
   always_ff @(posedge clk_i) begin
      if (reg_write_i && (rd_i != '0)) begin
         regs[rd_i] <= wr_data_i;
      end
   end

   assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

   // pc, port and sticky halt
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc_o       <= bus_pkg::reset_pc;
         out_data_o <= '0;
         halted_o   <= 1'b0;
      end else begin
         if (pc_load_i) begin
            pc_o <= pc_target_i;
         end else if (pc_step_i) begin
            pc_o <= pc_o + 32'd4;
         end
         if (out_write_i) begin
            out_data_o <= rs1_val_o[bus_pkg::out_port_width-1:0];
         end
         if (halt_set_i) begin
            halted_o <= 1'b1;
         end
      end
   end

   a_pc_one_update: assert property (@(posedge clk_i) disable iff (reset_i)
      !(pc_step_i && pc_load_i));

endmodule

// File: team_01_cpu.sv
`timescale 1ns/1ps
/*
 * Multi-cycle sequencer: fetch, decode, execute, memory, write-back.
 * en_i low holds off the next fetch only; a running instruction completes.
 * After HALT the sequencer stays idle until reset.
 */
module team_01_cpu (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  logic                               en_i,
   input  logic                               busy_i,
   input  logic [bus_pkg::wb_data_width-1:0]  bus_dat_i,
   output logic                               read_o,
   output logic                               write_o,
   output logic [bus_pkg::wb_addr_width-1:0]  adr_o,
   output logic [bus_pkg::wb_sel_width-1:0]   sel_o,
   output logic [bus_pkg::wb_data_width-1:0]  bus_dat_o,
   output logic [bus_pkg::out_port_width-1:0] out_data_o,
   output logic                               halted_o
);

   typedef enum logic [2:0] {
      s_fetch_req,
      s_fetch_wait,
      s_decode,
      s_execute,
      s_mem_req,
      s_mem_wait,
      s_writeback,
      s_halted
   } state_t;

   state_t state_q;

   logic [cpu_pkg::data_width-1:0]     instr_q;
   logic [cpu_pkg::data_width-1:0]     alu_q;
   logic [cpu_pkg::data_width-1:0]     load_q;
   logic [cpu_pkg::opcode_width-1:0]   opcode;
   logic [cpu_pkg::reg_addr_width-1:0] rd;
   logic [cpu_pkg::reg_addr_width-1:0] rs1;
   logic [cpu_pkg::reg_addr_width-1:0] rs2;
   logic [cpu_pkg::data_width-1:0]     imm;
   logic [cpu_pkg::alu_op_width-1:0]   alu_op;
   logic uses_imm;
   logic reg_write;
   logic mem_read;
   logic mem_write;
   logic branch;
   logic out_write;
   logic halt;
   logic [cpu_pkg::data_width-1:0]     rs1_val;
   logic [cpu_pkg::data_width-1:0]     rs2_val;
   logic [cpu_pkg::data_width-1:0]     pc;
   logic [cpu_pkg::data_width-1:0]     alu_result;
   logic [cpu_pkg::data_width-1:0]     branch_target;
   logic [cpu_pkg::data_width-1:0]     wr_data;
   logic operands_differ;
   logic in_wb;
   logic taken;

   cpu_decode u_decode (
      .instr_i     (instr_q),
      .opcode_o    (opcode),
      .rd_o        (rd),
      .rs1_o       (rs1),
      .rs2_o       (rs2),
      .imm_o       (imm),
      .alu_op_o    (alu_op),
      .uses_imm_o  (uses_imm),
      .reg_write_o (reg_write),
      .mem_read_o  (mem_read),
      .mem_write_o (mem_write),
      .branch_o    (branch),
      .out_write_o (out_write),
      .halt_o      (halt)
   );

   cpu_execute u_execute (
      .alu_op_i          (alu_op),
      .uses_imm_i        (uses_imm),
      .rs1_val_i         (rs1_val),
      .rs2_val_i         (rs2_val),
      .imm_i             (imm),
      .pc_i              (pc),
      .alu_result_o      (alu_result),
      .branch_target_o   (branch_target),
      .operands_differ_o (operands_differ)
   );

   // Write-back strobes, all in one cycle
   assign in_wb   = (state_q == s_writeback);
   assign taken   = branch && operands_differ;
   assign wr_data = (opcode == cpu_pkg::op_ld) ? load_q : alu_q;

   cpu_result u_result (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .reg_write_i (in_wb && reg_write),
      .rd_i        (rd),
      .wr_data_i   (wr_data),
      .rs1_i       (rs1),
      .rs2_i       (rs2),
      .rs1_val_o   (rs1_val),
      .rs2_val_o   (rs2_val),
      .pc_step_i   (in_wb && !halt && !taken),
      .pc_load_i   (in_wb && taken),
      .pc_target_i (branch_target),
      .pc_o        (pc),
      .out_write_i (in_wb && out_write),
      .out_data_o  (out_data_o),
      .halt_set_i  (in_wb && halt),
      .halted_o    (halted_o)
   );

   // Bus strobes only while the manager is idle
   assign read_o    = !busy_i && (((state_q == s_fetch_req) && en_i) ||
                                  ((state_q == s_mem_req) && mem_read));
   assign write_o   = !busy_i && (state_q == s_mem_req) && mem_write;
   assign adr_o     = (state_q == s_mem_req) ? alu_q : pc;
   assign sel_o     = bus_pkg::wb_sel_all;
   // Store data from rs2
   assign bus_dat_o = rs2_val;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= s_fetch_req;
      end else begin
         case (state_q)
            s_fetch_req:
               if (en_i && !busy_i) state_q <= s_fetch_wait;
            // Busy falls the cycle after ACK
            s_fetch_wait:
               if (!busy_i) state_q <= s_decode;
            s_decode:
               state_q <= s_execute;
            s_execute:
               state_q <= (mem_read || mem_write) ? s_mem_req : s_writeback;
            s_mem_req:
               if (!busy_i) state_q <= s_mem_wait;
            s_mem_wait:
               if (!busy_i) state_q <= s_writeback;
            s_writeback:
               state_q <= halt ? s_halted : s_fetch_req;
            default:
               state_q <= s_halted;
         endcase
      end
   end

   // Instruction, ALU result and load data
   always_ff @(posedge clk_i) begin
      if ((state_q == s_fetch_wait) && !busy_i) begin
         instr_q <= bus_dat_i;
      end
      if (state_q == s_execute) begin
         alu_q <= alu_result;
      end
      if ((state_q == s_mem_wait) && !busy_i) begin
         load_q <= bus_dat_i;
      end
   end

endmodule

// File: team_01.sv
`timescale 1ns/1ps
/*
 * Chip top: processor and Wishbone manager on the student slot pins.
 * Output port on gpio 11..4, halt flag on gpio 0; logic analyzer unused.
 */
module team_01 (
   input  logic          clk_i,
   input  logic          reset_i,
   input  logic          en_i,
   input  logic [127:0]  la_data_i,
   output logic [127:0]  la_data_o,
   input  logic [127:0]  la_oenb_i,
   input  logic [33:0]   gpio_i,
   output logic [33:0]   gpio_o,
   output logic [33:0]   gpio_oeb_o,
   input  logic [31:0]   dat_i,
   input  logic          ack_i,
   output logic [31:0]   adr_o,
   output logic [31:0]   dat_o,
   output logic [3:0]    sel_o,
   output logic          we_o,
   output logic          stb_o,
   output logic          cyc_o
);

   logic        read;
   logic        write;
   logic        busy;
   logic [31:0] req_adr;
   logic [31:0] req_dat;
   logic [31:0] rsp_dat;
   logic [3:0]  req_sel;
   logic [7:0]  out_data;
   logic        halted;

   team_01_cpu u_cpu (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .en_i       (en_i),
      .busy_i     (busy),
      .bus_dat_i  (rsp_dat),
      .read_o     (read),
      .write_o    (write),
      .adr_o      (req_adr),
      .sel_o      (req_sel),
      .bus_dat_o  (req_dat),
      .out_data_o (out_data),
      .halted_o   (halted)
   );

   wishbone_manager u_wb (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .read_i    (read),
      .write_i   (write),
      .adr_i     (req_adr),
      .sel_i     (req_sel),
      .cpu_dat_i (req_dat),
      .cpu_dat_o (rsp_dat),
      .busy_o    (busy),
      .dat_i     (dat_i),
      .ack_i     (ack_i),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .sel_o     (sel_o),
      .we_o      (we_o),
      .stb_o     (stb_o),
      .cyc_o     (cyc_o)
   );

   // LCD data bus position on the breakout
   assign gpio_o     = {22'b0, out_data, 3'b0, halted};
   // Active low enables, pins 0 and 11..4 driven
   assign gpio_oeb_o = {22'h3f_ffff, 8'h00, 3'b111, 1'b0};
   assign la_data_o  = '0;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps
/*
 * Free-running 20 ns clock and synchronous reset for the testbench.
 * Reset is high from time zero and drops after the fourth rising edge.
 */
module tb_clock_gen #(
   parameter int half_period  = 10,
   parameter int reset_cycles = 4
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #half_period clk_o = ~clk_o;
   end

   // Synchronous release on a rising edge
   initial begin
      reset_o <= 1'b1;
      repeat (reset_cycles) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

// File: tb_team_01.sv
`timescale 1ns/1ps
/*
 * Testbench for team_01 with a 256-word Wishbone memory model.
 * Acknowledge delay is 0 to 4 cycles from an xorshift source, seed 59704.
 * The run stops at the first mismatch and is limited to 3000 cycles.
 */
module tb_team_01;

   localparam int mem_words     = 256;
   localparam int program_len   = 31;
   // Word index of the preloaded operands at byte 0x200
   localparam int data_base     = 128;
   localparam int result_count  = 9;
   localparam int out_count     = 5;
   localparam int enable_start  = 150;
   localparam int enable_cycles = 50;
   // Worst case tail of one instruction with two bus cycles
   localparam int enable_settle = 20;
   localparam int halt_quiet    = 100;
   // Rounded up from 120 instructions x (2 bus cycles x 6 + 6 sequencing)
   localparam int timeout_cycles = 3000;
   localparam logic [31:0] rng_seed = 32'd59704;
   // GPIO pins other than 0 and 11..4
   localparam logic [33:0] undriven_pins = 34'h3_ffff_f00e;

   function automatic logic [31:0] encode_instr(input logic [3:0] op, input int rd,
                                                input int rs1, input int rs2, input int imm);
      encode_instr = {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000, 16'(imm)};
   endfunction

   // Program words from address 0 upward
   localparam logic [31:0] program_table [program_len] = '{
      encode_instr(cpu_pkg::op_lui,  1, 0, 0, 'h1234),
      encode_instr(cpu_pkg::op_addi, 1, 1, 0, 'h5678),
      encode_instr(cpu_pkg::op_addi, 2, 0, 0, -1),
      encode_instr(cpu_pkg::op_add,  3, 1, 2, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 3, 'h280),
      encode_instr(cpu_pkg::op_sub,  3, 0, 1, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 3, 'h284),
      encode_instr(cpu_pkg::op_lui,  4, 0, 0, 'hff00),
      encode_instr(cpu_pkg::op_addi, 4, 4, 0, 'h0f0f),
      encode_instr(cpu_pkg::op_and,  3, 1, 4, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 3, 'h288),
      encode_instr(cpu_pkg::op_or,   3, 1, 4, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 3, 'h28c),
      encode_instr(cpu_pkg::op_xor,  3, 1, 4, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 3, 'h290),
      encode_instr(cpu_pkg::op_addi, 5, 2, 0, 'h8000),
      encode_instr(cpu_pkg::op_st,   0, 0, 5, 'h294),
      encode_instr(cpu_pkg::op_ld,   5, 0, 0, 'h200),
      encode_instr(cpu_pkg::op_addi, 6, 0, 0, 'h200),
      encode_instr(cpu_pkg::op_ld,   6, 6, 0, 4),
      encode_instr(cpu_pkg::op_add,  7, 5, 6, 0),
      encode_instr(cpu_pkg::op_st,   0, 0, 7, 'h298),
      encode_instr(cpu_pkg::op_xor,  7, 5, 6, 0),
      encode_instr(cpu_pkg::op_addi, 1, 0, 0, 'h290),
      encode_instr(cpu_pkg::op_st,   0, 1, 7, 'h00c),
      encode_instr(cpu_pkg::op_addi, 1, 0, 0, 5),
      // Loop body starts at word 26 and branches back 3 words
      encode_instr(cpu_pkg::op_out,  0, 1, 0, 0),
      encode_instr(cpu_pkg::op_addi, 1, 1, 0, -1),
      encode_instr(cpu_pkg::op_bne,  0, 1, 0, -3),
      encode_instr(cpu_pkg::op_st,   0, 0, 1, 'h2a0),
      encode_instr(cpu_pkg::op_halt, 0, 0, 0, 0)
   };

   localparam logic [31:0] data_table [2] = '{32'h8000_0003, 32'h7fff_fffe};

   // Byte address and word expected there after HALT
   localparam logic [31:0] result_addr [result_count] = '{
      32'h280, 32'h284, 32'h288, 32'h28c, 32'h290, 32'h294, 32'h298, 32'h29c, 32'h2a0
   };
   localparam logic [31:0] result_word [result_count] = '{
      32'h1234_5677, 32'hedcb_a988, 32'h1200_0608, 32'hff34_5f7f, 32'hed34_5977,
      32'hffff_7fff, 32'h0000_0001, 32'hffff_fffd, 32'h0000_0000
   };
   localparam logic [7:0] out_table [out_count] = '{8'd5, 8'd4, 8'd3, 8'd2, 8'd1};

   logic         clk;
   logic         reset;
   logic         en;
   logic [127:0] la_data_in;
   logic [127:0] la_data_out;
   logic [127:0] la_oenb;
   logic [33:0]  gpio_in;
   logic [33:0]  gpio_out;
   logic [33:0]  gpio_oeb;
   logic [31:0]  wb_rdata = '0;
   logic         wb_ack = 1'b0;
   logic [31:0]  wb_adr;
   logic [31:0]  wb_wdata;
   logic [3:0]   wb_sel;
   logic         wb_we;
   logic         wb_stb;
   logic         wb_cyc;
   logic [31:0]  mem [mem_words];
   logic [31:0]  rng_q;
   logic [2:0]   delay_left;
   int           cycle_count = 0;
   logic [7:0]   last_port = '0;
   logic [7:0]   out_seen [$];

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Fill word shows every address bit
   function automatic logic [31:0] fill_word(input logic [7:0] idx);
      return {8'hc3, idx, ~idx, idx ^ 8'h5a};
   endfunction

   task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("Finished with errors");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   tb_clock_gen u_clock_gen (
      .clk_o   (clk),
      .reset_o (reset)
   );

   team_01 u_dut (
      .clk_i      (clk),
      .reset_i    (reset),
      .en_i       (en),
      .la_data_i  (la_data_in),
      .la_data_o  (la_data_out),
      .la_oenb_i  (la_oenb),
      .gpio_i     (gpio_in),
      .gpio_o     (gpio_out),
      .gpio_oeb_o (gpio_oeb),
      .dat_i      (wb_rdata),
      .ack_i      (wb_ack),
      .adr_o      (wb_adr),
      .dat_o      (wb_wdata),
      .sel_o      (wb_sel),
      .we_o       (wb_we),
      .stb_o      (wb_stb),
      .cyc_o      (wb_cyc)
   );

   // Memory model loaded while reset is high
   always @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < mem_words; k++) begin
            mem[8'(k)] <= fill_word(8'(k));
         end
         for (int k = 0; k < program_len; k++) begin
            mem[8'(k)] <= program_table[5'(k)];
         end
         mem[8'(data_base)]     <= data_table[0];
         mem[8'(data_base + 1)] <= data_table[1];
         wb_ack     <= 1'b0;
         rng_q      <= xorshift32(rng_seed);
         delay_left <= 3'(xorshift32(rng_seed) % 32'd5);
      end else if (wb_ack) begin
         wb_ack <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
         if (delay_left == 3'd0) begin
            check_value(128'(wb_sel), 128'hf, "Wishbone select lanes");
            wb_ack   <= 1'b1;
            wb_rdata <= mem[wb_adr[9:2]];
            if (wb_we) begin
               mem[wb_adr[9:2]] <= wb_wdata;
            end
            // Next delay drawn now
            rng_q      <= xorshift32(rng_q);
            delay_left <= 3'(xorshift32(rng_q) % 32'd5);
         end else begin
            delay_left <= delay_left - 3'd1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout: the run exceeded %0d cycles", timeout_cycles);
         $display("Finished with errors");
         $fatal(1, "cycle limit reached");
      end
   end

   // LA pins and the output-port history
   always @(negedge clk) begin
      check_value(la_data_out, 128'd0, "la_data_o not zero");
      if (!reset && gpio_out[11:4] != last_port) begin
         out_seen.push_back(gpio_out[11:4]);
         last_port <= gpio_out[11:4];
      end
   end

   initial begin
      en         <= 1'b1;
      la_data_in <= '0;
      la_oenb    <= '1;
      gpio_in    <= '0;

      // Reset cycles and the first cycle after release
      do begin
         @(posedge clk);
         @(negedge clk);
         check_value(128'(wb_cyc), 128'd0, "cyc_o around reset");
         check_value(128'(wb_stb), 128'd0, "stb_o around reset");
         check_value(128'(wb_we), 128'd0, "we_o around reset");
         check_value(128'(gpio_out), 128'd0, "gpio_o around reset");
         check_value(128'(gpio_oeb), 128'(undriven_pins), "gpio_oeb_o");
      end while (reset);

      repeat (enable_start) @(posedge clk);
      @(negedge clk);
      check_value(128'(gpio_out[0]), 128'd0, "processor halted before the enable window");
      @(posedge clk);
      en <= 1'b0;
      repeat (enable_settle) @(posedge clk);
      repeat (enable_cycles - enable_settle) begin
         @(negedge clk);
         check_value(128'(wb_cyc), 128'd0, "bus cycle started while en_i low");
      end
      @(posedge clk);
      en <= 1'b1;

      while (gpio_out[0] !== 1'b1) @(negedge clk);
      check_value(128'(gpio_out & undriven_pins), 128'd0, "unused gpio_o bits");
      repeat (halt_quiet) begin
         @(negedge clk);
         check_value(128'(wb_cyc), 128'd0, "bus cycle after halt");
      end

      for (int i = 0; i < result_count; i++) begin
         check_value(128'(mem[result_addr[4'(i)][9:2]]), 128'(result_word[4'(i)]),
                     $sformatf("memory word at 0x%03h", result_addr[4'(i)]));
      end
      check_value(128'(out_seen.size()), 128'(out_count), "number of output-port changes");
      for (int i = 0; i < out_count; i++) begin
         check_value(128'(out_seen[i]), 128'(out_table[3'(i)]),
                     $sformatf("output-port value %0d", i));
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: filelist.f
cpu_pkg.sv
bus_pkg.sv
wishbone_manager.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
team_01_cpu.sv
team_01.sv
tb_clock_gen.sv
tb_team_01.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the team_01 testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_team_01 \
   -Mdir "$obj_dir" -o tb_team_01 > "$build_log" 2>&1
build_status=$?
cat "$build_log"
if [ "$build_status" -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"./$obj_dir/tb_team_01" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Finished with errors" "$sim_log"; then
   echo "Simulation FAILED"
   exit 1
fi
if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
echo "Simulation passed"
exit 0
